// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_pov_top
FILELIST  := pov_display.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := TEST FAILED
PASS_MSG  := TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== pov_display.f ====
src/pov_pkg.sv
src/pov_ifs.sv
src/spi_slave.sv
src/spi_decoder.sv
src/rotation_tracker.sv
src/led_driver_ctrl.sv
src/pov_top.sv
tests/tb_pov_top.sv

// ==== src/led_driver_ctrl.sv ====
// Rows scan only while rgb_enable is set; a start of frame cuts the current row short and restarts at row 0
module led_driver_ctrl
   import pov_pkg::*;
(
   input  logic                 clk,
   input  logic                 arst_n,
   drv_ctrl_if.sink             drv,
   input  logic                 sof,
   output logic                 drv_sclk,
   output logic                 drv_lat,
   output logic [SIN_LANES-1:0] drv_sin,
   output logic [ROWS-1:0]      fpga_mul
);

   drv_state_e state;

   logic [TICK_BITS-1:0]    tick_cnt;
   logic [BIT_CNT_BITS-1:0] bit_cnt;
   logic [ROW_BITS-1:0]     row;
   logic                    tick_end;
   logic                    start_row;
   logic                    shift_en;

   // Last clock of a driver tick
   assign tick_end = (tick_cnt == TICK_BITS'(CLK_DIV - 1));

   // Fresh row from idle, after a start of frame, or after the row step
   assign start_row = drv.rgb_enable &&
                      (sof || (state == IDLE) || ((state == NEXT_ROW) && tick_end));
   assign shift_en  = !start_row && (state == SHIFT) && tick_end;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= IDLE;
         tick_cnt <= '0;
         bit_cnt  <= '0;
         row      <= '0;
      end else if (!drv.rgb_enable) begin
         // Display off, park the scan
         state    <= IDLE;
         tick_cnt <= '0;
         bit_cnt  <= '0;
         row      <= '0;
      end else if (start_row) begin
         state    <= SHIFT;
         tick_cnt <= '0;
         bit_cnt  <= '0;
         if (sof || (state == IDLE) || (row == ROW_BITS'(ROWS - 1))) begin
            row <= '0;
         end else begin
            row <= row + 1'b1;
         end
      end else begin
         tick_cnt <= tick_end ? '0 : tick_cnt + 1'b1;
         if (tick_end) begin
            case (state)
               SHIFT: begin
                  // 24 bits per lane, then the latch tick
                  if (bit_cnt == BIT_CNT_BITS'(LANE_BITS - 1)) begin
                     state <= LATCH;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end
               LATCH: begin
                  state <= NEXT_ROW;
               end
               default: begin
               end
            endcase
         end
      end
   end

   // One shift register per lane, reloaded at each row start
   for (genvar k = 0; k < SIN_LANES; k++) begin : g_lane
      logic [LANE_BITS-1:0] lane_sr;

      always_ff @(posedge clk) begin
         if (start_row) begin
            // Lane k takes column bits 24k up to 24k+23
            lane_sr <= drv.column_data[k*LANE_BITS +: LANE_BITS];
         end else if (shift_en) begin
            lane_sr <= {lane_sr[LANE_BITS-2:0], 1'b0};
         end
      end

      // MSB first, zeros while the display is off
      assign drv_sin[k] = drv.rgb_enable && (state == SHIFT) && lane_sr[LANE_BITS-1];
   end

   // Driver clock high in the second half of each shift tick
   assign drv_sclk = (state == SHIFT) && (tick_cnt >= TICK_BITS'(CLK_DIV / 2));
   assign drv_lat  = (state == LATCH);

   // One-hot row select, host override wins
   always_comb begin
      fpga_mul = '0;
      if (drv.mux_override) begin
         fpga_mul[drv.mux_row] = 1'b1;
      end else if (state != IDLE) begin
         fpga_mul[row] = 1'b1;
      end
   end

   // Latch must never see a clock edge
   a_lat_sclk : assert property (@(posedge clk) disable iff (!arst_n)
      !(drv_lat && drv_sclk));

endmodule

// ==== src/pov_ifs.sv ====
// Both bundles carry plain register values; the frame strobe has no back-pressure
interface spi_frame_if
   import pov_pkg::*;
();

   // Received frame, first byte in the top byte
   logic [FRAME_BITS-1:0]  data_mosi;
   logic [LEN_BITS-1:0]    data_len_bytes;
   // One-cycle strobe per complete frame
   logic                   valid;
   // Status word returned on the next frame
   logic [STATUS_BITS-1:0] data_miso;

   modport slave   (output data_mosi, data_len_bytes, valid, input data_miso);
   modport decoder (input data_mosi, data_len_bytes, valid, output data_miso);

endinterface

interface drv_ctrl_if
   import pov_pkg::*;
();

   // Display registers written by the host
   logic [COL_BITS-1:0] column_data;
   logic                rgb_enable;
   logic                mux_override;
   logic [ROW_BITS-1:0] mux_row;

   modport source (output column_data, rgb_enable, mux_override, mux_row);
   modport sink   (input column_data, rgb_enable, mux_override, mux_row);

endinterface

// ==== src/pov_pkg.sv ====
// Sizes fit one 96-bit column on four 24-bit driver lanes and 8 rows; opcode values match the host tool
package pov_pkg;

   // Driver geometry
   localparam int SIN_LANES = 4;
   localparam int LANE_BITS = 24;
   localparam int COL_BITS = SIN_LANES * LANE_BITS;
   localparam int ROWS = 8;
   localparam int ROW_BITS = $clog2(ROWS);
   localparam int BIT_CNT_BITS = $clog2(LANE_BITS);

   // Clocks per driver tick
   localparam int CLK_DIV = 4;
   localparam int TICK_BITS = $clog2(CLK_DIV);

   // SPI frame sizes, opcode byte plus one column at most
   localparam int MAX_FRAME_BYTES = 1 + COL_BITS / 8;
   localparam int CTRL_FRAME_BYTES = 2;
   localparam int FRAME_BITS = 8 * MAX_FRAME_BYTES;
   localparam int LEN_BITS = 4;

   // Revolution count in upper half, period in lower half
   localparam int STATUS_BITS = 32;

   // Host command opcodes
   typedef enum logic [7:0] {
      CMD_SET_COLUMN = 8'h03,
      CMD_SET_MUX    = 8'h04,
      CMD_ENABLE     = 8'h05
   } cmd_e;

   // Driver controller states
   typedef enum logic [1:0] {
      IDLE,
      SHIFT,
      LATCH,
      NEXT_ROW
   } drv_state_e;

endpackage

// ==== src/pov_top.sv ====
// Single clock domain; SPI and hall pins are asynchronous and are synchronized inside the blocks
module pov_top
   import pov_pkg::*;
(
   input  logic                 clk,
   input  logic                 arst_n,
   // Host SPI link
   input  logic                 som_cs,
   input  logic                 som_sclk,
   input  logic                 som_mosi,
   output logic                 som_miso,
   // Hall sensor
   input  logic                 hall,
   // LED drivers and row mux
   output logic                 drv_sclk,
   output logic                 drv_lat,
   output logic [SIN_LANES-1:0] drv_sin,
   output logic [ROWS-1:0]      fpga_mul
);

   spi_frame_if frame_if ();
   drv_ctrl_if  drv_if ();

   logic        sof;
   logic [15:0] rotation_data;
   logic [15:0] speed_data;

   spi_slave u_spi_slave (
      .clk      (clk),
      .arst_n   (arst_n),
      .som_cs   (som_cs),
      .som_sclk (som_sclk),
      .som_mosi (som_mosi),
      .som_miso (som_miso),
      .frame    (frame_if.slave)
   );

   spi_decoder u_spi_decoder (
      .clk           (clk),
      .arst_n        (arst_n),
      .frame         (frame_if.decoder),
      .rotation_data (rotation_data),
      .speed_data    (speed_data),
      .drv           (drv_if.source)
   );

   rotation_tracker u_rotation_tracker (
      .clk           (clk),
      .arst_n        (arst_n),
      .hall          (hall),
      .sof           (sof),
      .rotation_data (rotation_data),
      .speed_data    (speed_data)
   );

   led_driver_ctrl u_led_driver_ctrl (
      .clk      (clk),
      .arst_n   (arst_n),
      .drv      (drv_if.sink),
      .sof      (sof),
      .drv_sclk (drv_sclk),
      .drv_lat  (drv_lat),
      .drv_sin  (drv_sin),
      .fpga_mul (fpga_mul)
   );

endmodule

// ==== src/rotation_tracker.sv ====
// One hall sensor; the period saturates at 16'hFFFF clocks and the revolution count wraps
module rotation_tracker (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        hall,
   output logic        sof,
   output logic [15:0] rotation_data,
   output logic [15:0] speed_data
);

   // Two sync stages plus one history stage
   logic [2:0]  hall_sync;
   logic        hall_rise;
   logic [15:0] period_cnt;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hall_sync <= '0;
      end else begin
         hall_sync <= {hall_sync[1:0], hall};
      end
   end

   assign hall_rise = hall_sync[1] & ~hall_sync[2];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sof           <= 1'b0;
         period_cnt    <= '0;
         rotation_data <= '0;
         speed_data    <= '0;
      end else begin
         // Start of frame three clocks after the pin edge
         sof <= hall_rise;
         if (hall_rise) begin
            speed_data    <= period_cnt;
            rotation_data <= rotation_data + 1'b1;
            // Counting restarts at one so the capture equals the edge spacing
            period_cnt    <= 16'd1;
         end else if (period_cnt != '1) begin
            period_cnt <= period_cnt + 1'b1;
         end
      end
   end

   // Start of frame is a strobe
   a_sof_pulse : assert property (@(posedge clk) disable iff (!arst_n)
      sof |=> !sof);

endmodule

// ==== src/spi_decoder.sv ====
// Frames with an unknown opcode or a length other than the opcode needs are dropped silently
module spi_decoder
   import pov_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n,
   spi_frame_if.decoder frame,
   input  logic [15:0]  rotation_data,
   input  logic [15:0]  speed_data,
   drv_ctrl_if.source   drv
);

   cmd_e       opcode;
   logic [7:0] arg_byte;
   logic       len_ok;
   logic       frame_ok;

   // Opcode in the top byte, first argument right after it
   assign opcode   = cmd_e'(frame.data_mosi[FRAME_BITS-1 -: 8]);
   assign arg_byte = frame.data_mosi[FRAME_BITS-9 -: 8];

   // Length has to match the opcode exactly
   always_comb begin
      case (opcode)
         CMD_SET_COLUMN: begin
            len_ok = (frame.data_len_bytes == LEN_BITS'(MAX_FRAME_BYTES));
         end
         CMD_SET_MUX, CMD_ENABLE: begin
            len_ok = (frame.data_len_bytes == LEN_BITS'(CTRL_FRAME_BYTES));
         end
         default: begin
            len_ok = 1'b0;
         end
      endcase
   end

   assign frame_ok = frame.valid && len_ok;

   // Column register, twelve payload bytes below the opcode
   always_ff @(posedge clk) begin
      if (frame_ok && (opcode == CMD_SET_COLUMN)) begin
         drv.column_data <= frame.data_mosi[FRAME_BITS-9 -: COL_BITS];
      end
   end

   // Control registers
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         drv.rgb_enable   <= 1'b0;
         drv.mux_override <= 1'b0;
         drv.mux_row      <= '0;
      end else if (frame_ok) begin
         if (opcode == CMD_ENABLE) begin
            drv.rgb_enable <= arg_byte[0];
         end
         if (opcode == CMD_SET_MUX) begin
            // Bit 7 forces the mux, low bits pick the row
            drv.mux_override <= arg_byte[7];
            drv.mux_row      <= arg_byte[ROW_BITS-1:0];
         end
      end
   end

   // Status word follows the tracker continuously
   assign frame.data_miso = {rotation_data, speed_data};

endmodule

// ==== src/spi_slave.sv ====
// SPI mode 0 target with MSB first; som_sclk must stay well below clk/4 since every pin passes a two-flop synchronizer
module spi_slave
   import pov_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       som_cs,
   input  logic       som_sclk,
   input  logic       som_mosi,
   output logic       som_miso,
   spi_frame_if.slave frame
);

   // Two sync stages plus one history stage for edge detection
   logic [2:0] cs_sync;
   logic [2:0] sclk_sync;
   logic [1:0] mosi_sync;

   logic cs_active;
   logic cs_fall;
   logic cs_rise;
   logic sclk_rise;
   logic sclk_fall;

   logic [2:0]             bit_cnt;
   logic [LEN_BITS-1:0]    byte_cnt;
   logic                   overrun;
   logic [LEN_BITS+2:0]    wr_idx;
   logic [FRAME_BITS-1:0]  frame_buf;
   logic [STATUS_BITS-1:0] miso_sr;

   // Chip select idles high
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cs_sync   <= '1;
         sclk_sync <= '0;
         mosi_sync <= '0;
      end else begin
         cs_sync   <= {cs_sync[1:0], som_cs};
         sclk_sync <= {sclk_sync[1:0], som_sclk};
         mosi_sync <= {mosi_sync[0], som_mosi};
      end
   end

   assign cs_active = ~cs_sync[1];
   assign cs_fall   = cs_sync[2] & ~cs_sync[1];
   assign cs_rise   = ~cs_sync[2] & cs_sync[1];
   // SCLK edges only count inside a frame
   assign sclk_rise = cs_active & sclk_sync[1] & ~sclk_sync[2];
   assign sclk_fall = cs_active & ~sclk_sync[1] & sclk_sync[2];

   // Bit position counted down from the top of the buffer
   assign wr_idx = (LEN_BITS + 3)'(FRAME_BITS - 1) - {byte_cnt, bit_cnt};

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         bit_cnt     <= '0;
         byte_cnt    <= '0;
         overrun     <= 1'b0;
         miso_sr     <= '0;
         frame.valid <= 1'b0;
      end else begin
         frame.valid <= 1'b0;
         if (cs_fall) begin
            // New frame, capture the status word for shifting out
            bit_cnt  <= '0;
            byte_cnt <= '0;
            overrun  <= 1'b0;
            miso_sr  <= frame.data_miso;
         end else if (cs_rise) begin
            // Only whole, in-range frames reach the decoder
            frame.valid <= (byte_cnt != '0) && !overrun;
            miso_sr     <= '0;
         end else begin
            if (sclk_rise) begin
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == 3'd7) begin
                  if (byte_cnt == LEN_BITS'(MAX_FRAME_BYTES)) begin
                     overrun <= 1'b1;
                  end else begin
                     byte_cnt <= byte_cnt + 1'b1;
                  end
               end
            end
            // Next MISO bit after each falling edge
            if (sclk_fall) begin
               miso_sr <= {miso_sr[STATUS_BITS-2:0], 1'b0};
            end
         end
      end
   end

   // Payload buffer, bits past the last byte are dropped
   always_ff @(posedge clk) begin
      if (sclk_rise && (byte_cnt < LEN_BITS'(MAX_FRAME_BYTES))) begin
         frame_buf[wr_idx] <= mosi_sync[1];
      end
   end

   assign frame.data_mosi      = frame_buf;
   assign frame.data_len_bytes = byte_cnt;
   assign som_miso             = miso_sr[STATUS_BITS-1];

   // Decoder sees exactly one strobe per frame
   a_valid_single : assert property (@(posedge clk) disable iff (!arst_n)
      frame.valid |=> !frame.valid);

endmodule

// ==== tests/tb_pov_top.sv ====
// Host SPI runs at clk/8; the hall period must fit in 16 bits; columns are written before enabling
module tb_pov_top
   import pov_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int SPI_HALF = 4;
   localparam int HALL_PERIOD = 300;
   localparam int LATCH_TIMEOUT = 400;
   localparam int MUX_ROW = 5;
   localparam logic [7:0] BAD_OPCODE = 8'h07;
   localparam logic [7:0] STATUS_OPCODE = 8'h00;

   logic                 clk = 1'b0;
   logic                 arst_n;
   logic                 som_cs;
   logic                 som_sclk;
   logic                 som_mosi;
   logic                 som_miso;
   logic                 hall;
   logic                 drv_sclk;
   logic                 drv_lat;
   logic [SIN_LANES-1:0] drv_sin;
   logic [ROWS-1:0]      fpga_mul;

   // Lane monitor, updated on falling clock edges
   logic                                sclk_q;
   logic                                lat_q;
   logic [SIN_LANES-1:0][LANE_BITS-1:0] mon_lanes;
   logic [SIN_LANES-1:0][LANE_BITS-1:0] lat_lanes;
   logic [ROWS-1:0]                     lat_row;
   int                                  lat_count;

   int                  errors;
   int                  checks;
   int                  hall_count;
   logic [COL_BITS-1:0] column;

   pov_top UUT (
      .clk      (clk),
      .arst_n   (arst_n),
      .som_cs   (som_cs),
      .som_sclk (som_sclk),
      .som_mosi (som_mosi),
      .som_miso (som_miso),
      .hall     (hall),
      .drv_sclk (drv_sclk),
      .drv_lat  (drv_lat),
      .drv_sin  (drv_sin),
      .fpga_mul (fpga_mul)
   );

   initial begin
      forever #10 clk = ~clk;
   end

   // Collect lane bits on drv_sclk rise, snapshot lanes and row on drv_lat rise
   always @(negedge clk) begin
      if (!arst_n) begin
         sclk_q    <= 1'b0;
         lat_q     <= 1'b0;
         mon_lanes <= '0;
         lat_count <= 0;
      end else begin
         if (drv_sclk && !sclk_q) begin
            for (int k = 0; k < SIN_LANES; k++) begin
               mon_lanes[k] <= {mon_lanes[k][LANE_BITS-2:0], drv_sin[k]};
            end
         end
         if (drv_lat && !lat_q) begin
            lat_lanes <= mon_lanes;
            lat_row   <= fpga_mul;
            lat_count <= lat_count + 1;
         end
         sclk_q <= drv_sclk;
         lat_q  <= drv_lat;
      end
   end

   task automatic check_lane(input string name, input logic [LANE_BITS-1:0] exp,
                             input logic [LANE_BITS-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Mismatch %s: expected 0x%h, actual 0x%h", name, exp, act);
      end
   endtask

   task automatic check_row(input string name, input logic [ROWS-1:0] exp,
                            input logic [ROWS-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Mismatch %s: expected 0x%h, actual 0x%h", name, exp, act);
      end
   endtask

   task automatic check_status(input string name, input logic [15:0] exp, input logic [15:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   function automatic logic [ROWS-1:0] one_hot(input int idx);
      logic [ROWS-1:0] v;
      v      = '0;
      v[idx] = 1'b1;
      return v;
   endfunction

   function automatic logic [COL_BITS-1:0] random_column();
      logic [COL_BITS-1:0] c;
      for (int i = 0; i < COL_BITS / 32; i++) begin
         c[32*i +: 32] = $urandom();
      end
      return c;
   endfunction

   // Mode 0 host, data changes while sclk is low, MISO sampled as sclk rises
   task automatic spi_transfer(input logic [FRAME_BITS-1:0] data, input int n_bytes,
                               output logic [STATUS_BITS-1:0] status);
      status = '0;
      @(negedge clk);
      som_cs = 1'b0;
      for (int i = 0; i < 8 * n_bytes; i++) begin
         som_mosi = data[FRAME_BITS-1-i];
         repeat (SPI_HALF) @(negedge clk);
         som_sclk = 1'b1;
         if (i < STATUS_BITS) begin
            status = {status[STATUS_BITS-2:0], som_miso};
         end
         repeat (SPI_HALF) @(negedge clk);
         som_sclk = 1'b0;
      end
      som_mosi = 1'b0;
      repeat (SPI_HALF) @(negedge clk);
      som_cs = 1'b1;
      // Valid within 4 clocks, decoder one clock later
      repeat (4 * SPI_HALF) @(negedge clk);
   endtask

   task automatic send_frame(input logic [7:0] opcode, input logic [COL_BITS-1:0] payload,
                             input int n_bytes);
      logic [STATUS_BITS-1:0] status;
      spi_transfer({opcode, payload}, n_bytes, status);
   endtask

   // Hall rising edges exactly spacing clocks apart
   task automatic apply_hall(input int pulses, input int spacing);
      for (int p = 0; p < pulses; p++) begin
         @(negedge clk);
         hall = 1'b1;
         repeat (4) @(negedge clk);
         hall = 1'b0;
         hall_count++;
         repeat (spacing - 5) @(negedge clk);
      end
   endtask

   task automatic wait_latch(output bit ok);
      int start;
      int waited;
      start  = lat_count;
      waited = 0;
      ok     = 1'b0;
      while (!ok && waited < LATCH_TIMEOUT) begin
         @(posedge clk);
         waited++;
         ok = (lat_count != start);
      end
      if (!ok) begin
         errors++;
         $display("Timeout: no driver latch within %0d cycles", LATCH_TIMEOUT);
      end
   endtask

   // Lane k carries column bits 24k up to 24k+23
   task automatic check_column(input string name, input logic [COL_BITS-1:0] col);
      for (int k = 0; k < SIN_LANES; k++) begin
         check_lane($sformatf("%s lane %0d", name, k),
                    col[k*LANE_BITS +: LANE_BITS], lat_lanes[k]);
      end
   endtask

   task automatic report_test(input string name, input int err0);
      if (errors == err0) begin
         $display("%-14s ok", name);
      end else begin
         $display("%-14s %0d errors", name, errors - err0);
      end
   endtask

   task automatic test_reset_state();
      int err0;
      int bad_cycles;
      err0       = errors;
      bad_cycles = 0;
      for (int i = 0; i < 100; i++) begin
         @(negedge clk);
         if ({drv_sclk, drv_lat, drv_sin, fpga_mul, som_miso} !== '0) begin
            bad_cycles++;
         end
      end
      checks++;
      if (bad_cycles != 0) begin
         errors++;
         $display("reset_state: outputs were not low on %0d of 100 cycles", bad_cycles);
      end
      report_test("reset_state", err0);
   endtask

   task automatic test_column_shift();
      int err0;
      bit ok;
      err0   = errors;
      column = random_column();
      send_frame(CMD_SET_COLUMN, column, MAX_FRAME_BYTES);
      send_frame(CMD_ENABLE, {8'h01, 88'h0}, 2);
      // Scan starts at row 0 and steps in order
      for (int r = 0; r < ROWS; r++) begin
         wait_latch(ok);
         if (ok) begin
            check_column("column_shift", column);
            check_row("column_shift row", one_hot(r), lat_row);
         end
      end
      report_test("column_shift", err0);
   endtask

   task automatic test_rotation_status();
      int err0;
      logic [STATUS_BITS-1:0] status;
      err0 = errors;
      apply_hall(3, HALL_PERIOD);
      // Unknown opcode, the frame only carries the status back
      spi_transfer({STATUS_OPCODE, 96'h0}, STATUS_BITS / 8, status);
      check_status("rotation_count", 16'(hall_count), status[STATUS_BITS-1 -: 16]);
      check_status("rotation_period", 16'(HALL_PERIOD), status[15:0]);
      report_test("rotation", err0);
   endtask

   task automatic test_mux_override();
      int err0;
      bit ok;
      logic [ROWS-1:0] prev;
      err0 = errors;
      send_frame(CMD_SET_MUX, {8'h80 | 8'(MUX_ROW), 88'h0}, 2);
      check_row("mux_override", one_hot(MUX_ROW), fpga_mul);
      // Forced row holds through the scan
      for (int i = 0; i < 2; i++) begin
         wait_latch(ok);
         if (ok) begin
            check_row("mux_override latch", one_hot(MUX_ROW), lat_row);
         end
      end
      send_frame(CMD_SET_MUX, 96'h0, 2);
      wait_latch(ok);
      prev = lat_row;
      wait_latch(ok);
      if (ok) begin
         check_row("mux_resume", {prev[ROWS-2:0], prev[ROWS-1]}, lat_row);
      end
      report_test("mux_override", err0);
   endtask

   task automatic test_bad_frames();
      int err0;
      bit ok;
      logic [COL_BITS-1:0] bad;
      err0 = errors;
      bad  = random_column();
      // One byte short, then a full frame with an unknown opcode
      send_frame(CMD_SET_COLUMN, bad, MAX_FRAME_BYTES - 1);
      send_frame(BAD_OPCODE, bad, MAX_FRAME_BYTES);
      wait_latch(ok);
      wait_latch(ok);
      if (ok) begin
         check_column("bad_frames", column);
      end
      report_test("bad_frames", err0);
   endtask

   task automatic test_sof_restart();
      int err0;
      int tries;
      bit ok;
      bit found;
      err0  = errors;
      tries = 0;
      found = 1'b0;
      while (!found && tries < ROWS + 2) begin
         wait_latch(ok);
         tries++;
         found = ok && (lat_row == one_hot(2));
      end
      if (!found) begin
         errors++;
         $display("sof_restart: row 2 was never latched");
      end else begin
         // Hall edge lands in the middle of row 3
         repeat (20) @(negedge clk);
         apply_hall(1, 10);
         wait_latch(ok);
         if (ok) begin
            check_row("sof_restart", one_hot(0), lat_row);
            check_column("sof_restart", column);
         end
      end
      report_test("sof_restart", err0);
   endtask

   initial begin
      arst_n     = 1'b0;
      som_cs     = 1'b1;
      som_sclk   = 1'b0;
      som_mosi   = 1'b0;
      hall       = 1'b0;
      errors     = 0;
      checks     = 0;
      hall_count = 0;
      void'($urandom(56376));
      repeat (10) @(negedge clk);
      arst_n = 1'b1;
      test_reset_state();
      test_column_shift();
      test_rotation_status();
      test_mux_override();
      test_bad_frames();
      test_sof_restart();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule
